//--- Bender.yml
package:
  name: issue_select

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/issueQueuePkg.sv
      - src/selectPortPkg.sv
      - src/priorityMask.sv
      - src/cascadedSelectBlock.sv
      - src/grantEncoder.sv
      - src/pipeStage.sv
      - src/issueSelect.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/issueSelectTb.sv

//--- include/issueSelect_settings.svh
// issue select sizing
`ifndef ISSUESELECT_SETTINGS_SVH
`define ISSUESELECT_SETTINGS_SVH

// entries held in the issue queue
`define ISSUEQ_SIZE 32

// bits needed for an entry index
`define ISSUEQ_SIZE_LOG 5

// entries covered by one stage-0 block
`define SELECT_BLOCK_SIZE 8

// grant ports, A first
`define ISSUE_PORTS 3

`endif

//--- src/cascadedSelectBlock.sv
// cascaded three grant select block
`timescale 1ns/10ps
`default_nettype none

`include "issueSelect_settings.svh"

module cascadedSelectBlock #(
	// groups handled here, entries at stage 0 or blocks at stage 1
	parameter int NUM_GROUPS = 8,
	// request lanes per group
	parameter int IN_LANES = 1
) (
	// lane-major, lane l of group g at l*NUM_GROUPS+g
	input wire [IN_LANES*NUM_GROUPS-1:0] reqLanes_i,
	// ports allowed to take a grant from this block
	input wire selectPortPkg::portMaskT grantEn_i,
	// port-major one-hot grants, port p at p*NUM_GROUPS
	output logic [`ISSUE_PORTS*NUM_GROUPS-1:0] grants_o,
	// bit k means at least k+1 requests here
	output wire [`ISSUE_PORTS-1:0] reqLanes_o
);

	localparam int FULL_WIDTH = IN_LANES * NUM_GROUPS;

	// group-major copy of the lanes
	logic [FULL_WIDTH-1:0] reqFull;
	// requests left before each pick
	logic [FULL_WIDTH-1:0] remain [`ISSUE_PORTS];
	// one-hot pick in lane space
	logic [FULL_WIDTH-1:0] pickFull [`ISSUE_PORTS];
	// pick folded back onto group positions
	logic [NUM_GROUPS-1:0] pickGroup [`ISSUE_PORTS];

	// interleave so all lanes of group 0 come first
	always_comb
	begin
		for (int g = 0; g < NUM_GROUPS; g++)
		begin
			for (int l = 0; l < IN_LANES; l++)
			begin
				reqFull[g*IN_LANES + l] = reqLanes_i[l*NUM_GROUPS + g];
			end
		end
	end

	// first pick sees every request
	assign remain[0] = reqFull;

	for (genvar k = 0; k < `ISSUE_PORTS; k++)
	begin : pickGen
		// earlier picks are removed
		if (k > 0)
		begin : peelGen
			assign remain[k] = remain[k-1] & ~pickFull[k-1];
		end

		// k-th lowest request overall
		priorityMask #(
			.WIDTH(FULL_WIDTH)
		) pickMask (
			.vector_i(remain[k]),
			.vector_o(pickFull[k])
		);

		// anything left means at least k+1 requests
		assign reqLanes_o[k] = |remain[k];

		// any lane of a group hit gives that group
		for (genvar g = 0; g < NUM_GROUPS; g++)
		begin : foldGen
			assign pickGroup[k][g] = |pickFull[k][g*IN_LANES +: IN_LANES];
		end
	end

	// picks go out in order to the enabled ports
	// a disabled port is skipped and keeps no grant
	always_comb
	begin
		int pickCnt;
		pickCnt = 0;
		grants_o = '0;
		for (int p = 0; p < `ISSUE_PORTS; p++)
		begin
			if (grantEn_i[p])
			begin
				grants_o[p*NUM_GROUPS +: NUM_GROUPS] = pickGroup[pickCnt];
				// next enabled port takes the next pick
				pickCnt++;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/grantEncoder.sv
// one-hot grant encoder
`timescale 1ns/10ps
`default_nettype none

`include "issueSelect_settings.svh"

module grantEncoder (
	// one-hot or empty grant vector
	input wire issueQueuePkg::entryVecT vector_i,
	output selectPortPkg::portGrantT grant_o
);

	// index built by OR of set positions
	issueQueuePkg::entryIdxT entryIdx;

	always_comb
	begin
		entryIdx = '0;
		// only one bit set, so OR gives its index
		for (int i = 0; i < `ISSUEQ_SIZE; i++)
		begin
			if (vector_i[i])
			begin
				entryIdx = entryIdx | issueQueuePkg::entryIdxT'(i);
			end
		end
	end

	// empty vector gives valid low and index zero
	assign grant_o = '{
		valid: |vector_i,
		entry: entryIdx,
		vector: vector_i
	};

endmodule

`default_nettype wire

//--- src/issueQueuePkg.sv
// issue queue entry types
`default_nettype none

package issueQueuePkg;

	`include "issueSelect_settings.svh"

	// one bit per queue entry
	// bit i is entry i, lowest index has priority
	typedef logic [`ISSUEQ_SIZE-1:0] entryVecT;

	// encoded entry number
	typedef logic [`ISSUEQ_SIZE_LOG-1:0] entryIdxT;

endpackage

`default_nettype wire

//--- src/issueSelect.sv
// issue queue select top
`timescale 1ns/10ps
`default_nettype none

`include "issueSelect_settings.svh"

module issueSelect (
	input wire clk,
	input wire rstN_i,

	// request input
	input wire inValid_i,
	output logic inReady_o,
	input wire selectPortPkg::selectReqT inReq_i,

	// grant output, two cycles after acceptance
	output logic outValid_o,
	input wire outReady_i,
	output selectPortPkg::grantResultT outResult_o
);

	// entries per stage-0 block
	localparam int BLOCK_SIZE = `SELECT_BLOCK_SIZE;
	// stage-0 blocks, also stage-1 groups
	localparam int NUM_BLOCKS = `ISSUEQ_SIZE / `SELECT_BLOCK_SIZE;

	// registered request feeding the tree
	logic reqValid;
	logic reqReady;
	selectPortPkg::selectReqT reqData;

	// stage-0 request lanes, lane-major for stage 1
	wire [`ISSUE_PORTS*NUM_BLOCKS-1:0] stage1Req;
	// stage-1 grants back to the blocks, port-major
	wire [`ISSUE_PORTS*NUM_BLOCKS-1:0] stage1Grant;

	// full one-hot grant per port
	wire issueQueuePkg::entryVecT grantVec [`ISSUE_PORTS];
	// encoded grants before the output stage
	wire selectPortPkg::grantResultT grantResult;

	// input register
	pipeStage #(
		.payloadT(selectPortPkg::selectReqT)
	) reqStage (
		.clk(clk),
		.rstN_i(rstN_i),
		.inValid_i(inValid_i),
		.inReady_o(inReady_o),
		.inData_i(inReq_i),
		.outValid_o(reqValid),
		.outReady_i(reqReady),
		.outData_o(reqData)
	);

	// stage 0, 32 entries into 4 blocks of 3 lanes
	for (genvar b = 0; b < NUM_BLOCKS; b++)
	begin : stage0Gen
		// at least 1, 2, 3 requests in this block
		wire [`ISSUE_PORTS-1:0] blockReq;
		// ports stage 1 handed to this block
		wire selectPortPkg::portMaskT blockEn;
		// port-major grant slices of this block
		wire [`ISSUE_PORTS*BLOCK_SIZE-1:0] blockGrant;

		cascadedSelectBlock #(
			.NUM_GROUPS(BLOCK_SIZE),
			.IN_LANES(1)
		) selectBlk (
			.reqLanes_i(reqData.requestVector[b*BLOCK_SIZE +: BLOCK_SIZE]),
			.grantEn_i(blockEn),
			.grants_o(blockGrant),
			.reqLanes_o(blockReq)
		);

		for (genvar p = 0; p < `ISSUE_PORTS; p++)
		begin : portGen
			// lane p of group b
			assign stage1Req[p*NUM_BLOCKS + b] = blockReq[p];
			// port p enabled here when stage 1 picked this block for it
			assign blockEn[p] = stage1Grant[p*NUM_BLOCKS + b];
			// block slice into the full port vector
			assign grantVec[p][b*BLOCK_SIZE +: BLOCK_SIZE] =
				blockGrant[p*BLOCK_SIZE +: BLOCK_SIZE];
		end
	end

	// stage 1, 12 lanes down to 3 grants
	// its request lanes have nothing above to feed
	cascadedSelectBlock #(
		.NUM_GROUPS(NUM_BLOCKS),
		.IN_LANES(`ISSUE_PORTS)
	) stage1Blk (
		.reqLanes_i(stage1Req),
		.grantEn_i(reqData.portEnable),
		.grants_o(stage1Grant),
		.reqLanes_o()
	);

	// one encoder per port
	for (genvar p = 0; p < `ISSUE_PORTS; p++)
	begin : encGen
		grantEncoder portEnc (
			.vector_i(grantVec[p]),
			.grant_o(grantResult[p])
		);
	end

	// output register
	pipeStage #(
		.payloadT(selectPortPkg::grantResultT)
	) resultStage (
		.clk(clk),
		.rstN_i(rstN_i),
		.inValid_i(reqValid),
		.inReady_o(reqReady),
		.inData_i(grantResult),
		.outValid_o(outValid_o),
		.outReady_i(outReady_i),
		.outData_o(outResult_o)
	);

endmodule

`default_nettype wire

//--- src/pipeStage.sv
// valid ready register slice
`timescale 1ns/10ps
`default_nettype none

module pipeStage #(
	// payload carried through the slice
	parameter type payloadT = logic
) (
	input wire clk,
	input wire rstN_i,

	// upstream side
	input wire inValid_i,
	output logic inReady_o,
	input wire payloadT inData_i,

	// downstream side
	output logic outValid_o,
	input wire outReady_i,
	output payloadT outData_o
);

	// slice holds an item
	logic fullQ;
	// held item
	payloadT dataQ;

	// free slot, or the held item leaves this cycle
	assign inReady_o = ~fullQ | outReady_i;

	// occupancy follows the upstream valid whenever the slot can change
	always_ff @(posedge clk or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			fullQ <= 1'b0;
		end
		else if (inReady_o)
		begin
			fullQ <= inValid_i;
		end
	end

	// load only on an accepted transfer, otherwise hold
	always_ff @(posedge clk)
	begin
		if (inReady_o && inValid_i)
		begin
			dataQ <= inData_i;
		end
	end

	assign outValid_o = fullQ;
	assign outData_o = dataQ;

endmodule

`default_nettype wire

//--- src/priorityMask.sv
// lowest set bit mask
`timescale 1ns/10ps
`default_nettype none

module priorityMask #(
	// vector width
	parameter int WIDTH = 8
) (
	input wire [WIDTH-1:0] vector_i,
	// only the lowest set bit of vector_i survives
	output logic [WIDTH-1:0] vector_o
);

	// bit j open while no lower input bit is set
	logic [WIDTH-1:0] passMask;

	always_comb
	begin
		// bit 0 always passes
		passMask[0] = 1'b1;
		// mask closes above the first set bit
		for (int j = 1; j < WIDTH; j++)
		begin
			passMask[j] = passMask[j-1] & ~vector_i[j-1];
		end
	end

	assign vector_o = vector_i & passMask;

endmodule

`default_nettype wire

//--- src/selectPortPkg.sv
// issue port request and grant types
`default_nettype none

package selectPortPkg;

	`include "issueSelect_settings.svh"

	// one enable per port
	// bit 0 is port A, then B, then C
	typedef logic [`ISSUE_PORTS-1:0] portMaskT;

	// one select request
	typedef struct packed {
		// entries ready to issue
		issueQueuePkg::entryVecT requestVector;
		// ports that may take a grant
		portMaskT portEnable;
	} selectReqT;

	// grant seen by a single port
	typedef struct packed {
		// port got an entry
		logic valid;
		// index of the granted entry
		issueQueuePkg::entryIdxT entry;
		// same grant as a one-hot vector
		issueQueuePkg::entryVecT vector;
	} portGrantT;

	// grants of all ports, element 0 is port A
	typedef portGrantT [`ISSUE_PORTS-1:0] grantResultT;

endpackage

`default_nettype wire

//--- tb.f
+incdir+include
src/issueQueuePkg.sv
src/selectPortPkg.sv
src/priorityMask.sv
src/cascadedSelectBlock.sv
src/grantEncoder.sv
src/pipeStage.sv
src/issueSelect.sv
verification/issueSelectTb.sv

//--- verification/issueSelectTb.sv
// issue select testbench
`timescale 1ns/10ps
`default_nettype none

`include "issueSelect_settings.svh"

module issueSelectTb;

	localparam int CLK_PERIOD = 100;
	// items per test group
	localparam int NUM_DIRECTED = 7;
	localparam int NUM_MASKED = 16;
	localparam int NUM_STREAM = 40;
	localparam int NUM_RANDOM = 60;
	localparam int NUM_TESTS = NUM_DIRECTED + NUM_MASKED + NUM_STREAM + NUM_RANDOM;
	// two items in flight leave well within this with outReady high
	localparam int DRAIN_CYCLES = 8;

	logic clk;
	logic rstN;
	logic inValid;
	logic inReady;
	selectPortPkg::selectReqT inReq;
	logic outValid;
	logic outReady;
	selectPortPkg::grantResultT outResult;

	// expected results and their accept cycles in order
	selectPortPkg::grantResultT expQ [$];
	int acceptQ [$];
	// items held inside the DUT
	int inFlight = 0;
	int cycleCnt = 0;
	// latency is exactly 2 while outReady stays high
	logic latencyCheck;
	// outReady drawn at random each cycle while set
	logic randomReady;
	logic [31:0] lfsrState;

	issueSelect i_dut (
		.clk(clk),
		.rstN_i(rstN),
		.inValid_i(inValid),
		.inReady_o(inReady),
		.inReq_i(inReq),
		.outValid_o(outValid),
		.outReady_i(outReady),
		.outResult_o(outResult)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// one step per bit with the shifted-out msb as the random bit
	task automatic takeBits(input int count, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			bits = {bits[30:0], lfsrState[31]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	// ports in order A B C take the lowest entry still free
	function automatic selectPortPkg::grantResultT refSelect(
		input issueQueuePkg::entryVecT reqVec,
		input selectPortPkg::portMaskT portEn
	);
		selectPortPkg::grantResultT result;
		issueQueuePkg::entryVecT remaining;
		logic found;
		result = '0;
		remaining = reqVec;
		for (int p = 0; p < `ISSUE_PORTS; p++)
		begin
			found = 1'b0;
			for (int i = 0; i < `ISSUEQ_SIZE; i++)
			begin
				if (portEn[p] && !found && remaining[i])
				begin
					found = 1'b1;
					result[p].valid = 1'b1;
					result[p].entry = issueQueuePkg::entryIdxT'(i);
					result[p].vector = issueQueuePkg::entryVecT'(1) << i;
					remaining[i] = 1'b0;
				end
			end
		end
		return result;
	endfunction

	task automatic reportFailure(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			reportFailure($sformatf("ERROR at %0t ns: %s is %0h, expected %0h",
				$time, name, actual, expected));
		end
	endtask

	// inputs read here are still the pre-edge values
	task automatic advanceCycle();
		logic [31:0] bits;
		@(posedge clk);
		if (randomReady)
		begin
			takeBits(1, bits);
			outReady <= bits[0];
		end
	endtask

	// valid and data held until the DUT takes them
	task automatic sendReq(input issueQueuePkg::entryVecT vec,
		input selectPortPkg::portMaskT mask);
		logic accepted;
		inValid <= 1'b1;
		inReq <= '{requestVector: vec, portEnable: mask};
		accepted = 1'b0;
		while (!accepted)
		begin
			advanceCycle();
			accepted = inReady;
		end
	endtask

	// bounded wait so a lost item is left in the queue
	task automatic drainOutputs();
		int waited;
		inValid <= 1'b0;
		randomReady = 1'b0;
		outReady <= 1'b1;
		waited = 0;
		do
		begin
			@(posedge clk);
			waited++;
		end
		while (expQ.size() != 0 && waited < DRAIN_CYCLES);
		repeat (2) @(posedge clk);
	endtask

	// output side handled first so inFlight is the pre-edge count
	always @(posedge clk)
	begin : scoreboard
		selectPortPkg::grantResultT expResult;
		int acceptCycle;
		if (rstN)
		begin
			// input side blocks only when both stages hold data
			checkValue("inReady_o", inReady, (inFlight < 2) || outReady);
			if (outValid && outReady)
			begin
				if (expQ.size() == 0)
				begin
					reportFailure("an output transfer came with no result expected");
				end
				else
				begin
					expResult = expQ.pop_front();
					acceptCycle = acceptQ.pop_front();
					inFlight--;
					for (int p = 0; p < `ISSUE_PORTS; p++)
					begin
						checkValue($sformatf("outResult_o[%0d].valid", p),
							outResult[p].valid, expResult[p].valid);
						checkValue($sformatf("outResult_o[%0d].entry", p),
							outResult[p].entry, expResult[p].entry);
						checkValue($sformatf("outResult_o[%0d].vector", p),
							outResult[p].vector, expResult[p].vector);
					end
					if (latencyCheck)
					begin
						checkValue("outValid_o latency", cycleCnt - acceptCycle, 2);
					end
				end
			end
			if (inValid && inReady)
			begin
				expQ.push_back(refSelect(inReq.requestVector, inReq.portEnable));
				acceptQ.push_back(cycleCnt);
				inFlight++;
			end
			cycleCnt++;
		end
	end

	initial
	begin
		#(NUM_TESTS * 20 * CLK_PERIOD);
		reportFailure("timeout, the DUT stopped delivering results");
	end

	initial
	begin
		issueQueuePkg::entryVecT directedVecs [NUM_DIRECTED];
		selectPortPkg::portMaskT partialMasks [4];
		logic [31:0] vecBits;
		logic [31:0] maskBits;
		logic [31:0] gapBits;
		int sent;
		// single, one block, spread, zero, all ones
		directedVecs = '{32'h0000_0400, 32'h0000_00b4, 32'h8010_0200, 32'h0100_1002,
			32'h8000_0000, 32'h0000_0000, 32'hffff_ffff};
		// A only, A and C, B and C, none
		partialMasks = '{3'b001, 3'b101, 3'b110, 3'b000};
		clk = 1'b0;
		rstN = 1'b0;
		inValid = 1'b0;
		inReq = '0;
		outReady = 1'b0;
		lfsrState = 32'h13be;
		latencyCheck = 1'b1;
		randomReady = 1'b0;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;

		// idle state right after reset
		@(posedge clk);
		checkValue("outValid_o", outValid, 1'b0);
		checkValue("inReady_o", inReady, 1'b1);
		outReady <= 1'b1;

		for (int i = 0; i < NUM_DIRECTED; i++)
		begin
			sendReq(directedVecs[i], 3'b111);
		end
		drainOutputs();

		for (int i = 0; i < NUM_MASKED; i++)
		begin
			takeBits(32, vecBits);
			sendReq(vecBits, partialMasks[i / 4]);
		end
		drainOutputs();

		// back to back stream gives one result per cycle
		for (int i = 0; i < NUM_STREAM; i++)
		begin
			takeBits(32, vecBits);
			takeBits(3, maskBits);
			sendReq(vecBits, maskBits[2:0]);
		end
		drainOutputs();

		// random gaps and back-pressure
		latencyCheck <= 1'b0;
		randomReady = 1'b1;
		sent = 0;
		while (sent < NUM_RANDOM)
		begin
			takeBits(2, gapBits);
			if (gapBits[1:0] != 2'b00)
			begin
				takeBits(32, vecBits);
				takeBits(3, maskBits);
				sendReq(vecBits, maskBits[2:0]);
				sent++;
			end
			else
			begin
				inValid <= 1'b0;
				advanceCycle();
			end
		end
		drainOutputs();

		if (expQ.size() != 0 || inFlight != 0)
		begin
			reportFailure("results were still expected at the end of the run");
		end
		else
		begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire
